/* vga_interface.f */
rtl/vga_pkg.sv
rtl/vga_bus_regs.sv
rtl/vga_frame_buffer.sv
rtl/vga_scan_timing.sv
rtl/vga_pixel_out.sv
rtl/vga_interface.sv
test/vga_interface_checker.sv
test/vga_interface_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the vga_interface testbench with Verilator
# the exit status is the simulator's: nonzero on any $fatal or assertion error

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module vga_interface_tb \
    -f vga_interface.f \
    -o vga_sim \
    && ./obj_dir/vga_sim \
    && echo "simulation run finished" \
    || { echo "simulation run failed"; exit 1; }

/* test/vga_interface_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module vga_interface_tb import vga_pkg::*; ();

    localparam int        CLK_PERIOD    = 100;
    localparam bus_addr_t BASE          = 16'hff24;
    localparam int        FRAME_CYCLES  = H_TOTAL * V_TOTAL;
    localparam int        FIRST_VISIBLE = (V_SYNC + V_BACK) * H_TOTAL;  // after v_sync fall
    localparam int        H_SYNC_START  = H_VISIBLE + H_FRONT;
    localparam int        WAIT_LIMIT    = 2 * FRAME_CYCLES + 1000;

    logic       clk;
    logic       reset;
    logic       enable;
    logic       write_en;
    bus_addr_t  addr;
    bus_data_t  data_in;
    bus_data_t  data_out;
    logic       h_sync;
    logic       v_sync;
    logic [1:0] r_out;
    logic [1:0] g_out;
    logic [1:0] b_out;
    pixel_t     rgb;

    pixel_t     model [0:FB_HEIGHT-1][0:FB_WIDTH-1];
    bit         model_valid [0:FB_HEIGHT-1][0:FB_WIDTH-1];
    integer     seed;

    bit         frame_arm;
    bit         frame_run;
    bit         frame_done;
    int         offset;        // cycles since the v_sync fall
    int         last_h_fall;
    logic       prev_h;
    logic       prev_v;

    assign rgb = {b_out, g_out, r_out};

    vga_interface dut_i (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .addr     (addr),
        .write_en (write_en),
        .data_in  (data_in),
        .data_out (data_out),
        .h_sync   (h_sync),
        .v_sync   (v_sync),
        .r_out    (r_out),
        .g_out    (g_out),
        .b_out    (b_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected 0x%0h actual 0x%0h",
                     $time, name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("ERROR at %0t: timed out waiting for %s", $time, what);
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    endtask

    task automatic bus_cycle(input logic en, input logic we, input bus_addr_t a,
                             input bus_data_t d);
        @(negedge clk);
        enable   = en;
        write_en = we;
        addr     = a;
        data_in  = d;
        @(negedge clk);
        enable   = 1'b0;
        write_en = 1'b0;
    endtask

    task automatic bus_read_check(input logic en, input bus_addr_t a,
                                  input bus_data_t expected, input string name);
        @(negedge clk);
        enable   = en;
        write_en = 1'b0;
        addr     = a;
        #(CLK_PERIOD / 4);  // mid low phase, data_out settled
        check_value(name, 32'(expected), 32'(data_out));
        @(negedge clk);
        enable = 1'b0;
    endtask

    task automatic write_pixel(input int h, input int v, input bus_data_t c);
        bus_cycle(1'b1, 1'b1, BASE + REG_H, bus_data_t'(h));
        bus_cycle(1'b1, 1'b1, BASE + REG_V, bus_data_t'(v));
        bus_cycle(1'b1, 1'b1, BASE + REG_COLOR, c);
        if (h < FB_WIDTH && v < FB_HEIGHT) begin
            model[v][h]       = c[5:0];
            model_valid[v][h] = 1'b1;
        end
    endtask

    function automatic pixel_t expected_pixel(input int x, input int y);
        if (x >= 0 && x < H_VISIBLE && y >= 0 && y < V_VISIBLE)
            return model[y / 4][x / 4];
        return '0;
    endfunction

    task automatic wait_vsync_fall();
        int   waited;
        logic last;
        logic fell;
        waited = 0;
        last   = v_sync;
        do begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
                stop_on_timeout("a v_sync falling edge");
            fell = last && !v_sync;
            last = v_sync;
        end while (!fell);
    endtask

    task automatic run_frame_check();
        int waited;
        waited = 0;
        @(posedge clk);
        frame_done = 1'b0;
        frame_arm  = 1'b1;
        while (!frame_done) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
                stop_on_timeout("the frame comparison to finish");
        end
    endtask

    // ------------------------------------------------------------------
    // frame compare, one whole frame from a v_sync fall to the next
    // ------------------------------------------------------------------
    always @(negedge clk) begin : frame_compare
        int   x;
        int   y;
        logic exp_h;
        logic exp_v;
        if (frame_arm && prev_v && !v_sync) begin
            frame_arm   = 1'b0;
            frame_run   = 1'b1;
            offset      = 0;
            last_h_fall = -1;
        end
        if (frame_run) begin
            x = H_TOTAL;
            y = V_TOTAL;
            if (offset >= FIRST_VISIBLE) begin
                x = (offset - FIRST_VISIBLE) % H_TOTAL;
                y = (offset - FIRST_VISIBLE) / H_TOTAL;
            end
            exp_h = !(offset % H_TOTAL >= H_SYNC_START
                      && offset % H_TOTAL < H_SYNC_START + H_SYNC);
            exp_v = !(offset < V_SYNC * H_TOTAL || offset == FRAME_CYCLES);
            check_value("h_sync", 32'(exp_h), 32'(h_sync));
            check_value("v_sync", 32'(exp_v), 32'(v_sync));
            if (x >= H_VISIBLE || y >= V_VISIBLE)
                check_value("rgb", 32'(expected_pixel(x, y)), 32'(rgb));
            else if (model_valid[y / 4][x / 4])
                check_value("rgb", 32'(expected_pixel(x, y)), 32'(rgb));
            if (prev_h && !h_sync) begin
                if (last_h_fall >= 0)
                    check_value("line_period", 32'(H_TOTAL), 32'(offset - last_h_fall));
                last_h_fall = offset;
            end
            if (offset == FRAME_CYCLES) begin
                frame_run  = 1'b0;
                frame_done = 1'b1;
            end else begin
                offset++;
            end
        end
        prev_h = h_sync;
        prev_v = v_sync;
    end

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    initial begin : main
        bus_data_t h_val;
        bus_data_t v_val;
        bus_data_t c_val;
        int        h;
        int        v;
        seed       = 32'hf6155b15;
        reset      = 1'b1;
        enable     = 1'b0;
        write_en   = 1'b0;
        addr       = '0;
        data_in    = '0;
        frame_arm  = 1'b0;
        frame_run  = 1'b0;
        frame_done = 1'b0;
        prev_h     = 1'b1;
        prev_v     = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < 4; i++)
            bus_read_check(1'b1, BASE + bus_addr_t'(i), 8'h00, "data_out");
        repeat (600) begin     // well before the first h_sync pulse
            @(negedge clk);
            check_value("h_sync", 32'd1, 32'(h_sync));
            check_value("v_sync", 32'd1, 32'(v_sync));
        end

        // register readback and writes that must miss
        h_val = bus_data_t'($random(seed));
        v_val = bus_data_t'($random(seed));
        c_val = bus_data_t'($random(seed));
        write_pixel(h_val, v_val, c_val);
        bus_cycle(1'b1, 1'b1, BASE + 16'd4, 8'h5a);
        bus_cycle(1'b1, 1'b1, BASE - 16'd4, 8'ha5);
        bus_cycle(1'b0, 1'b1, BASE + REG_H, 8'h3c);
        bus_read_check(1'b1, BASE + REG_H, h_val, "h_reg");
        bus_read_check(1'b1, BASE + REG_V, v_val, "v_reg");
        bus_read_check(1'b1, BASE + REG_COLOR, c_val, "color_reg");
        bus_read_check(1'b1, BASE + 16'd4, 8'h00, "data_out");
        bus_read_check(1'b1, BASE - 16'd4, 8'h00, "data_out");
        bus_read_check(1'b0, BASE + REG_H, 8'h00, "data_out");

        repeat (40) begin
            h = {$random(seed)} % FB_WIDTH;
            v = {$random(seed)} % FB_HEIGHT;
            write_pixel(h, v, bus_data_t'($random(seed)));
        end
        run_frame_check();

        // each miss aims at the address of a pixel just written
        for (int i = 0; i < 10; i++) begin
            c_val = bus_data_t'($random(seed));
            if (i % 2 == 0) begin
                h = {$random(seed)} % (256 - FB_WIDTH);
                v = {$random(seed)} % (FB_HEIGHT - 1);
                write_pixel(h, v + 1, c_val);
                write_pixel(h + FB_WIDTH, v, ~c_val);   // same address as (h, v + 1)
            end else begin
                h = {$random(seed)} % (FB_WIDTH - 32);
                v = 205 + {$random(seed)} % (256 - 205);
                write_pixel(h + 32, v - 205, c_val);
                write_pixel(h, v, ~c_val);              // 15-bit address wraps here
            end
        end
        run_frame_check();

        // vblank status around the top of the frame
        wait_vsync_fall();
        bus_read_check(1'b1, BASE + REG_STATUS, 8'h01, "status");
        repeat (FIRST_VISIBLE + 10 - 3) @(negedge clk);  // read lands at fall + 28010
        bus_read_check(1'b1, BASE + REG_STATUS, 8'h00, "status");

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* test/vga_interface_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module vga_interface_checker import vga_pkg::*; #(
    parameter bit check_color = 1'b1
) (
    input wire logic   clk,
    input wire logic   reset,
    input wire logic   h_sync,
    input wire logic   v_sync,
    input wire logic   active,
    input wire pixel_t color
);

    int h_low;    // length of the current low pulse so far
    int v_low;

    always_ff @(posedge clk) begin
        if (reset) begin
            h_low <= 0;
            v_low <= 0;
        end else begin
            h_low <= h_sync ? 0 : h_low + 1;
            v_low <= v_sync ? 0 : v_low + 1;
        end
    end

    // ------------------------------------------------------------------
    // sync pulse widths, checked when the pulse ends
    // ------------------------------------------------------------------
    h_sync_width: assert property (@(posedge clk) disable iff (reset)
        $rose(h_sync) |-> h_low == H_SYNC)
        else $error("h_sync pulse lasted %0d cycles", h_low);

    v_sync_width: assert property (@(posedge clk) disable iff (reset)
        $rose(v_sync) |-> v_low == V_SYNC * H_TOTAL)
        else $error("v_sync pulse lasted %0d cycles", v_low);

    // output colour follows the counter side active flag two cycles later
    if (check_color) begin : g_blank
        blank_color: assert property (@(posedge clk) disable iff (reset)
            !active |=> ##1 color == '0)
            else $error("colour not blank outside the visible area");
    end

endmodule

bind vga_pixel_out vga_interface_checker pixel_out_chk_i (
    .clk    (clk),
    .reset  (reset),
    .h_sync (h_sync),
    .v_sync (v_sync),
    .active (scan.active),
    .color  ({b_out, g_out, r_out})
);

bind vga_scan_timing vga_interface_checker #(
    .check_color (1'b0)
) scan_timing_chk_i (
    .clk    (clk),
    .reset  (reset),
    .h_sync (scan.h_sync),
    .v_sync (scan.v_sync),
    .active (scan.active),
    .color  (6'd0)      // no colour on the counter side
);

`default_nettype wire

/* rtl/vga_interface.sv */
`timescale 1ns/10ps
`default_nettype none

module vga_interface import vga_pkg::*; #(
    parameter bus_addr_t base_addr = 16'hff24
) (
    input  wire logic      clk,
    input  wire logic      reset,
    // system bus
    input  wire logic      enable,
    input  wire bus_addr_t addr,
    input  wire logic      write_en,
    input  wire bus_data_t data_in,
    output bus_data_t      data_out,
    // video out
    output logic           h_sync,
    output logic           v_sync,
    output logic [1:0]     r_out,
    output logic [1:0]     g_out,
    output logic [1:0]     b_out
);

    pixel_write_t pix_wr;
    scan_pos_t    scan;
    pixel_t       rd_data;
    logic         vblank;

    // ------------------------------------------------------------------
    // bus side
    // ------------------------------------------------------------------
    vga_bus_regs #(
        .base_addr (base_addr)
    ) bus_regs_i (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .addr     (addr),
        .write_en (write_en),
        .data_in  (data_in),
        .vblank   (vblank),
        .data_out (data_out),
        .pix_wr   (pix_wr)
    );

    vga_frame_buffer frame_buffer_i (
        .clk     (clk),
        .pix_wr  (pix_wr),
        .rd_addr (scan.fb_addr),
        .rd_data (rd_data)
    );

    // ------------------------------------------------------------------
    // scan side
    // ------------------------------------------------------------------
    vga_scan_timing scan_timing_i (
        .clk    (clk),
        .reset  (reset),
        .scan   (scan),
        .vblank (vblank)
    );

    vga_pixel_out pixel_out_i (
        .clk     (clk),
        .reset   (reset),
        .scan    (scan),
        .rd_data (rd_data),
        .h_sync  (h_sync),
        .v_sync  (v_sync),
        .r_out   (r_out),
        .g_out   (g_out),
        .b_out   (b_out)
    );

endmodule

`default_nettype wire

/* rtl/vga_pixel_out.sv */
`timescale 1ns/10ps
`default_nettype none

module vga_pixel_out import vga_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire scan_pos_t scan,
    input  wire pixel_t    rd_data,
    output logic           h_sync,
    output logic           v_sync,
    output logic [1:0]     r_out,
    output logic [1:0]     g_out,
    output logic [1:0]     b_out
);

    // stage 1, lines up with the memory read
    logic   active_d;
    logic   h_sync_d;
    logic   v_sync_d;

    pixel_t color_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            active_d <= 1'b0;
            h_sync_d <= 1'b1;
            v_sync_d <= 1'b1;
        end else begin
            active_d <= scan.active;
            h_sync_d <= scan.h_sync;
            v_sync_d <= scan.v_sync;
        end
    end

    // stage 2, output registers
    always_ff @(posedge clk) begin
        if (reset) begin
            h_sync  <= 1'b1;
            v_sync  <= 1'b1;
            color_q <= '0;
        end else begin
            h_sync  <= h_sync_d;
            v_sync  <= v_sync_d;
            color_q <= active_d ? rd_data : '0;   // black in the porches
        end
    end

    assign r_out = color_q[1:0];
    assign g_out = color_q[3:2];
    assign b_out = color_q[5:4];

endmodule

`default_nettype wire

/* rtl/vga_scan_timing.sv */
`timescale 1ns/10ps
`default_nettype none

module vga_scan_timing import vga_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset,
    output scan_pos_t   scan,
    output logic        vblank
);

    h_count_t h_count;
    v_count_t v_count;
    fb_addr_t fb_addr;
    fb_addr_t row_start;     // first word of the current block row

    logic     line_end;
    logic     frame_end;
    logic     next_block;
    logic     next_row;

    assign line_end  = h_count == h_count_t'(H_TOTAL - 1);
    assign frame_end = v_count == v_count_t'(V_TOTAL - 1);

    // ------------------------------------------------------------------
    // counters
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            h_count <= '0;
            v_count <= '0;
        end else if (line_end) begin
            h_count <= '0;
            v_count <= frame_end ? '0 : v_count + 1'b1;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // frame buffer read address, 4 columns and 4 lines per word
    // ------------------------------------------------------------------
    // last column of a block, not past the visible edge
    assign next_block = h_count[1:0] == 2'd3 && h_count < h_count_t'(H_VISIBLE - 1);
    // last line of a block row, stays inside the buffer
    assign next_row   = v_count[1:0] == 2'd3 && v_count < v_count_t'(V_VISIBLE - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            fb_addr   <= '0;
            row_start <= '0;
        end else if (line_end) begin
            if (frame_end) begin
                fb_addr   <= '0;
                row_start <= '0;
            end else if (next_row) begin
                fb_addr   <= row_start + fb_addr_t'(FB_WIDTH);
                row_start <= row_start + fb_addr_t'(FB_WIDTH);
            end else begin
                fb_addr <= row_start;   // same block row again
            end
        end else if (next_block) begin
            fb_addr <= fb_addr + 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // flags
    // ------------------------------------------------------------------
    assign scan.fb_addr = fb_addr;
    assign scan.active  = h_count < h_count_t'(H_VISIBLE) && v_count < v_count_t'(V_VISIBLE);
    assign scan.h_sync  = !(h_count >= h_count_t'(H_VISIBLE + H_FRONT)
                         && h_count <  h_count_t'(H_VISIBLE + H_FRONT + H_SYNC));
    assign scan.v_sync  = !(v_count >= v_count_t'(V_VISIBLE + V_FRONT)
                         && v_count <  v_count_t'(V_VISIBLE + V_FRONT + V_SYNC));

    assign vblank = v_count >= v_count_t'(V_VISIBLE);

endmodule

`default_nettype wire

/* rtl/vga_frame_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module vga_frame_buffer import vga_pkg::*; (
    input  wire logic         clk,
    input  wire pixel_write_t pix_wr,
    input  wire fb_addr_t     rd_addr,
    output pixel_t            rd_data
);

    // one word per 4x4 block of the screen
    pixel_t mem [0:FB_DEPTH-1];

    // bus side write port
    always_ff @(posedge clk) begin
        if (pix_wr.valid) begin
            mem[pix_wr.addr] <= pix_wr.pixel;
        end
    end

    // scan side, one cycle read latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* rtl/vga_bus_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module vga_bus_regs import vga_pkg::*; #(
    parameter bus_addr_t base_addr = 16'hff24
) (
    input  wire logic         clk,
    input  wire logic         reset,
    input  wire logic         enable,
    input  wire bus_addr_t    addr,
    input  wire logic         write_en,
    input  wire bus_data_t    data_in,
    input  wire logic         vblank,
    output bus_data_t         data_out,
    output pixel_write_t      pix_wr
);

    logic       selected;
    logic [1:0] offset;
    logic       reg_write;
    logic       in_range;

    bus_data_t  h_reg;
    bus_data_t  v_reg;
    bus_data_t  color_reg;

    logic       wr_valid;
    fb_addr_t   wr_addr;
    pixel_t     wr_pixel;

    // ------------------------------------------------------------------
    // decode
    // ------------------------------------------------------------------
    assign selected  = enable && addr >= base_addr && addr <= base_addr + 3;
    assign offset    = 2'(addr - base_addr);
    assign reg_write = selected && write_en;

    // coordinates as they stand before the colour write
    assign in_range = h_reg < bus_data_t'(FB_WIDTH) && v_reg < bus_data_t'(FB_HEIGHT);

    always_ff @(posedge clk) begin
        if (reset) begin
            h_reg     <= '0;
            v_reg     <= '0;
            color_reg <= '0;
            wr_valid  <= 1'b0;
        end else begin
            wr_valid <= 1'b0;
            if (reg_write) begin
                case (offset)
                    REG_H:     h_reg <= data_in;
                    REG_V:     v_reg <= data_in;
                    REG_COLOR: begin
                        color_reg <= data_in;
                        wr_valid  <= in_range;
                    end
                    default:   ; // status is read only
                endcase
            end
        end
    end

    // write payload, only meaningful with wr_valid
    always_ff @(posedge clk) begin
        wr_addr  <= fb_addr_t'(v_reg) * fb_addr_t'(FB_WIDTH) + fb_addr_t'(h_reg);
        wr_pixel <= data_in[5:0];
    end

    assign pix_wr.valid = wr_valid;
    assign pix_wr.addr  = wr_addr;
    assign pix_wr.pixel = wr_pixel;

    // ------------------------------------------------------------------
    // readback
    // ------------------------------------------------------------------
    always_comb begin
        data_out = '0;
        if (selected) begin
            case (offset)
                REG_H:      data_out = h_reg;
                REG_V:      data_out = v_reg;
                REG_COLOR:  data_out = color_reg;
                REG_STATUS: data_out = {7'b0, vblank};
                default:    data_out = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/vga_pkg.sv */
`default_nettype none

package vga_pkg;

    // ------------------------------------------------------------------
    // basic widths
    // ------------------------------------------------------------------
    typedef logic [15:0] bus_addr_t;
    typedef logic [7:0]  bus_data_t;
    typedef logic [5:0]  pixel_t;      // {blue, green, red}, 2 bits each
    typedef logic [14:0] fb_addr_t;
    typedef logic [9:0]  h_count_t;    // 0..799
    typedef logic [9:0]  v_count_t;    // 0..524

    // frame buffer geometry, one word per 4x4 screen block
    localparam int FB_WIDTH  = 160;
    localparam int FB_HEIGHT = 120;
    localparam int FB_DEPTH  = FB_WIDTH * FB_HEIGHT;

    // ------------------------------------------------------------------
    // 640x480 line and frame timing, in pixel clocks and lines
    // ------------------------------------------------------------------
    localparam int H_VISIBLE = 640;
    localparam int H_FRONT   = 16;
    localparam int H_SYNC    = 96;
    localparam int H_BACK    = 48;
    localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;

    localparam int V_VISIBLE = 480;
    localparam int V_FRONT   = 10;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 33;
    localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

    // register offsets inside the bus window
    localparam logic [1:0] REG_H      = 2'd0;
    localparam logic [1:0] REG_V      = 2'd1;
    localparam logic [1:0] REG_COLOR  = 2'd2;
    localparam logic [1:0] REG_STATUS = 2'd3;

    typedef struct packed {
        logic     valid;
        fb_addr_t addr;
        pixel_t   pixel;
    } pixel_write_t;

    typedef struct packed {
        fb_addr_t fb_addr;    // read address for the current counters
        logic     active;
        logic     h_sync;     // active low
        logic     v_sync;     // active low
    } scan_pos_t;

endpackage

`default_nettype wire
